//--- rtl/arcade_io_pkg.sv
//==========================================================================
// Arcade I/O shared definitions
// Scan codes, button positions, DAC levels, PLL management words and
// download stream indices used across the input and config glue
//==========================================================================
`default_nettype none

package arcade_io_pkg;

	// PS/2 event word, toggle in bit 10, pressed in bit 9, code in 7..0
	localparam int KEY_EVENT_W = 11;

	// System keys
	localparam logic [7:0] SC_START1  = 8'h16;
	localparam logic [7:0] SC_START2  = 8'h1E;
	localparam logic [7:0] SC_COIN1   = 8'h2E;
	localparam logic [7:0] SC_COIN2   = 8'h36;
	localparam logic [7:0] SC_SERVICE = 8'h46;
	localparam logic [7:0] SC_PAUSE   = 8'h4D;

	// Player keys, cursor block plus ctrl and alt
	localparam logic [7:0] SC_UP      = 8'h75;
	localparam logic [7:0] SC_DOWN    = 8'h72;
	localparam logic [7:0] SC_LEFT    = 8'h6B;
	localparam logic [7:0] SC_RIGHT   = 8'h74;
	localparam logic [7:0] SC_SHOT    = 8'h14;
	localparam logic [7:0] SC_MISSILE = 8'h11;

	// Bit positions in the 12-bit held-button vector
	typedef enum logic [3:0] {
		BTN_START1  = 4'd0,
		BTN_START2  = 4'd1,
		BTN_COIN1   = 4'd2,
		BTN_COIN2   = 4'd3,
		BTN_SERVICE = 4'd4,
		BTN_PAUSE   = 4'd5,
		BTN_UP      = 4'd6,
		BTN_DOWN    = 4'd7,
		BTN_LEFT    = 4'd8,
		BTN_RIGHT   = 4'd9,
		BTN_SHOT    = 4'd10,
		BTN_MISSILE = 4'd11
	} btn_idx_e;

	// Measured output of the weighted resistor DAC on the PCB
	localparam logic [7:0] COLOR_LEVELS [16] = '{
		8'd0,   8'd14,  8'd31,  8'd45,
		8'd66,  8'd80,  8'd96,  8'd111,
		8'd144, 8'd158, 8'd175, 8'd190,
		8'd210, 8'd225, 8'd241, 8'd255
	};

	// PLL management registers
	localparam logic [5:0] PLL_ADDR_MODE  = 6'd0;
	localparam logic [5:0] PLL_ADDR_FRAC  = 6'd7;
	localparam logic [5:0] PLL_ADDR_START = 6'd2;

	// Fractional divider words, native rate and ~1% slower for 60 Hz vsync
	localparam logic [31:0] PLL_FRAC_NATIVE     = 32'd3639383488;
	localparam logic [31:0] PLL_FRAC_UNDERCLOCK = 32'd3262113561;

	// Download stream targets
	localparam logic [7:0] DL_INDEX_ROM = 8'd1;
	localparam logic [7:0] DL_INDEX_DIP = 8'd254;

endpackage

`default_nettype wire

//--- rtl/ps2_button_decoder.sv
//==========================================================================
// PS/2 button decoder
// Tracks twelve held keys from the PS/2 key-event word
//==========================================================================
`default_nettype none

module ps2_button_decoder
	import arcade_io_pkg::*;
(
	input  wire logic                   CLK_49M,
	input  wire logic                   arst_n,
	input  wire logic [KEY_EVENT_W-1:0] ps2_key,
	output logic      [11:0]            buttons
);

	// Event fields
	logic       pressed;
	logic [7:0] code;
	logic       toggle_q;
	logic       key_event;

	assign pressed = ps2_key[9];
	assign code    = ps2_key[7:0];

	// New event whenever bit 10 flips
	assign key_event = ps2_key[10] != toggle_q;

	//======================================================================
	// Held-key state
	//======================================================================
	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q <= 1'b0;
			buttons  <= '0;
		end else begin
			toggle_q <= ps2_key[10];
			if (key_event) begin
				// Unlisted codes fall through untouched
				case (code)
					SC_START1:  buttons[BTN_START1]  <= pressed;
					SC_START2:  buttons[BTN_START2]  <= pressed;
					SC_COIN1:   buttons[BTN_COIN1]   <= pressed;
					SC_COIN2:   buttons[BTN_COIN2]   <= pressed;
					SC_SERVICE: buttons[BTN_SERVICE] <= pressed;
					SC_PAUSE:   buttons[BTN_PAUSE]   <= pressed;
					// Player keys
					SC_UP:      buttons[BTN_UP]      <= pressed;
					SC_DOWN:    buttons[BTN_DOWN]    <= pressed;
					SC_LEFT:    buttons[BTN_LEFT]    <= pressed;
					SC_RIGHT:   buttons[BTN_RIGHT]   <= pressed;
					SC_SHOT:    buttons[BTN_SHOT]    <= pressed;
					SC_MISSILE: buttons[BTN_MISSILE] <= pressed;
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/control_mapper.sv
//==========================================================================
// Control mapper
// Merges held keys and USB joystick words into active-low game controls
//==========================================================================
`default_nettype none

module control_mapper
	import arcade_io_pkg::*;
(
	input  wire logic [11:0] buttons,
	input  wire logic [15:0] joystick_0,
	input  wire logic [15:0] joystick_1,
	output logic      [1:0]  coin,
	output logic      [1:0]  start_buttons,
	output logic      [3:0]  p1_joystick,
	output logic      [3:0]  p2_joystick,
	output logic      [2:0]  p1_buttons,
	output logic      [1:0]  p2_buttons,
	output logic             btn_service,
	output logic             pause_n
);

	// Joystick word bit positions
	localparam int JOY_RIGHT   = 0;
	localparam int JOY_LEFT    = 1;
	localparam int JOY_DOWN    = 2;
	localparam int JOY_UP      = 3;
	localparam int JOY_SHOT    = 4;
	localparam int JOY_MISSILE = 5;
	localparam int JOY_START1  = 6;
	localparam int JOY_COIN1   = 7;
	localparam int JOY_START2  = 8;
	localparam int JOY_PAUSE   = 9;

	// Either pad may drive the shared system buttons
	logic [15:0] joy_any;
	logic [5:0]  m_p1;
	logic [5:0]  m_p2;
	logic [5:0]  kb_player;

	assign joy_any = joystick_0 | joystick_1;

	// Keyboard player keys in joystick bit order
	assign kb_player = {buttons[BTN_MISSILE], buttons[BTN_SHOT], buttons[BTN_UP],
		buttons[BTN_DOWN], buttons[BTN_LEFT], buttons[BTN_RIGHT]};

	// Keyboard drives both players
	assign m_p1 = kb_player | joystick_0[JOY_MISSILE:JOY_RIGHT];
	assign m_p2 = kb_player | joystick_1[JOY_MISSILE:JOY_RIGHT];

	//======================================================================
	// Active-low outputs in game core order
	//======================================================================
	assign coin          = ~{buttons[BTN_COIN2], buttons[BTN_COIN1] | joy_any[JOY_COIN1]};
	assign start_buttons = ~{buttons[BTN_START2] | joy_any[JOY_START2],
		buttons[BTN_START1] | joy_any[JOY_START1]};
	// Right, left, down, up
	assign p1_joystick   = ~{m_p1[JOY_RIGHT], m_p1[JOY_LEFT], m_p1[JOY_DOWN], m_p1[JOY_UP]};
	assign p2_joystick   = ~{m_p2[JOY_RIGHT], m_p2[JOY_LEFT], m_p2[JOY_DOWN], m_p2[JOY_UP]};
	// Third P1 button unused on this board
	assign p1_buttons    = {1'b1, ~m_p1[JOY_MISSILE], ~m_p1[JOY_SHOT]};
	assign p2_buttons    = ~{m_p2[JOY_MISSILE], m_p2[JOY_SHOT]};
	assign btn_service   = ~buttons[BTN_SERVICE];
	assign pause_n       = ~(buttons[BTN_PAUSE] | joy_any[JOY_PAUSE]);

endmodule

`default_nettype wire

//--- rtl/dip_config_regs.sv
//==========================================================================
// DIP switch and ROM set capture
// Holds DIP bytes and the set-3 flag written by the download stream
//==========================================================================
`default_nettype none

module dip_config_regs
	import arcade_io_pkg::*;
#(
	parameter int DIP_BANKS = 2
) (
	input  wire logic        CLK_49M,
	input  wire logic        arst_n,
	input  wire logic        ioctl_wr,
	input  wire logic [7:0]  ioctl_index,
	input  wire logic [24:0] ioctl_addr,
	input  wire logic [7:0]  ioctl_dout,
	output logic      [15:0] dip_sw,
	output logic             is_set3
);

	localparam int BANK_W = (DIP_BANKS > 1) ? $clog2(DIP_BANKS) : 1;

	// Stored bytes hold the active-low menu settings
	logic [7:0]        dip_bytes [DIP_BANKS];
	logic              dip_hit;
	logic              rom_hit;
	logic [BANK_W-1:0] bank_sel;

	// Address decode
	assign dip_hit  = ioctl_wr && (ioctl_index == DL_INDEX_DIP) &&
		(ioctl_addr < 25'(DIP_BANKS));
	assign rom_hit  = ioctl_wr && (ioctl_index == DL_INDEX_ROM) && (ioctl_addr == '0);
	assign bank_sel = ioctl_addr[BANK_W-1:0];

	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DIP_BANKS; i++) begin
				dip_bytes[i] <= '0;
			end
			is_set3 <= 1'b0;
		end else begin
			if (dip_hit) begin
				dip_bytes[bank_sel] <= ioctl_dout;
			end
			// First ROM byte flags the set-3 board
			if (rom_hit) begin
				is_set3 <= ioctl_dout[0];
			end
		end
	end

	// Bank 1 in the high byte, missing banks read as switches off
	always_comb begin
		dip_sw = '1;
		for (int i = 0; i < DIP_BANKS; i++) begin
			if (i < 2) begin
				dip_sw[i*8 +: 8] = ~dip_bytes[i];
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/pll_reconfig_seq.sv
//==========================================================================
// PLL reconfiguration sequencer
// Applies the underclock setting through three management writes
// whenever the synchronised setting settles on a new value
//==========================================================================
`default_nettype none

module pll_reconfig_seq
	import arcade_io_pkg::*;
(
	input  wire logic        CLK_49M,
	input  wire logic        arst_n,
	input  wire logic        underclock,
	input  wire logic        cfg_waitrequest,
	output logic             cfg_write,
	output logic      [5:0]  cfg_address,
	output logic      [31:0] cfg_data
);

	// Write steps of the eight-step sequence
	localparam logic [2:0] STEP_MODE  = 3'd1;
	localparam logic [2:0] STEP_FRAC  = 3'd5;
	localparam logic [2:0] STEP_START = 3'd7;

	logic       uc_meta;
	logic       uc_sync;
	logic       uc_applied;
	logic [2:0] step;
	logic       seq_start;
	logic       write_step;

	// Settled, new, and no sequence in flight
	assign seq_start = (uc_meta == uc_sync) && (uc_sync != uc_applied) && (step == 3'd0);

	//======================================================================
	// Synchroniser and step counter
	//======================================================================
	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n) begin
			uc_meta    <= 1'b0;
			uc_sync    <= 1'b0;
			uc_applied <= 1'b0;
			step       <= 3'd0;
		end else begin
			uc_meta <= underclock;
			uc_sync <= uc_meta;
			if (seq_start) begin
				step       <= STEP_MODE;
				uc_applied <= uc_sync;
			end else if (!cfg_waitrequest && (step != 3'd0)) begin
				// Freezes under back-pressure, wraps to idle after step 7
				step <= step + 3'd1;
			end
		end
	end

	//======================================================================
	// Management port
	//======================================================================
	assign write_step = (step == STEP_MODE) || (step == STEP_FRAC) || (step == STEP_START);

	// Only on accepted cycles, so each step pulses once
	assign cfg_write = write_step && !cfg_waitrequest;

	always_comb begin
		cfg_address = PLL_ADDR_MODE;
		cfg_data    = '0;
		case (step)
			STEP_FRAC: begin
				cfg_address = PLL_ADDR_FRAC;
				cfg_data    = uc_applied ? PLL_FRAC_UNDERCLOCK : PLL_FRAC_NATIVE;
			end
			STEP_START: cfg_address = PLL_ADDR_START;
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/color_dac.sv
//==========================================================================
// Colour DAC table
// 4-bit channels to 24-bit RGB through the measured levels
//==========================================================================
`default_nettype none

module color_dac
	import arcade_io_pkg::*;
(
	input  wire logic [3:0]  r_in,
	input  wire logic [3:0]  g_in,
	input  wire logic [3:0]  b_in,
	output logic      [23:0] rgb_out
);

	logic [7:0] r_lvl;
	logic [7:0] g_lvl;
	logic [7:0] b_lvl;

	// Per-channel lookup
	assign r_lvl = COLOR_LEVELS[r_in];
	assign g_lvl = COLOR_LEVELS[g_in];
	assign b_lvl = COLOR_LEVELS[b_in];

	// Red in the top byte
	assign rgb_out = {r_lvl, g_lvl, b_lvl};

endmodule

`default_nettype wire

//--- rtl/tp84_io_top.sv
//==========================================================================
// Arcade board I/O top level
// Keyboard and joystick controls, DIP capture, colour table and PLL
// reconfiguration for the game core
//==========================================================================
`default_nettype none

module tp84_io_top
	import arcade_io_pkg::*;
#(
	parameter int DIP_BANKS = 2
) (
	input  wire logic                   CLK_49M,
	input  wire logic                   arst_n,
	// Keyboard and USB pads
	input  wire logic [KEY_EVENT_W-1:0] ps2_key,
	input  wire logic [15:0]            joystick_0,
	input  wire logic [15:0]            joystick_1,
	// Download stream
	input  wire logic                   ioctl_wr,
	input  wire logic [7:0]             ioctl_index,
	input  wire logic [24:0]            ioctl_addr,
	input  wire logic [7:0]             ioctl_dout,
	// PLL management
	input  wire logic                   underclock,
	input  wire logic                   cfg_waitrequest,
	output logic                        cfg_write,
	output logic      [5:0]             cfg_address,
	output logic      [31:0]            cfg_data,
	// Game controls, active low
	output logic      [1:0]             coin,
	output logic      [1:0]             start_buttons,
	output logic      [3:0]             p1_joystick,
	output logic      [3:0]             p2_joystick,
	output logic      [2:0]             p1_buttons,
	output logic      [1:0]             p2_buttons,
	output logic                        btn_service,
	output logic                        pause_n,
	// Board configuration
	output logic      [15:0]            dip_sw,
	output logic                        is_set3,
	// Video colour
	input  wire logic [3:0]             r_in,
	input  wire logic [3:0]             g_in,
	input  wire logic [3:0]             b_in,
	output logic      [23:0]            rgb_out
);

	// Held keys, decoder to mapper
	logic [11:0] buttons;

	ps2_button_decoder ps2_button_decoder_i (
		.CLK_49M (CLK_49M),
		.arst_n  (arst_n),
		.ps2_key (ps2_key),
		.buttons (buttons)
	);

	control_mapper control_mapper_i (
		.buttons       (buttons),
		.joystick_0    (joystick_0),
		.joystick_1    (joystick_1),
		.coin          (coin),
		.start_buttons (start_buttons),
		.p1_joystick   (p1_joystick),
		.p2_joystick   (p2_joystick),
		.p1_buttons    (p1_buttons),
		.p2_buttons    (p2_buttons),
		.btn_service   (btn_service),
		.pause_n       (pause_n)
	);

	// Configuration registers next to the controls they steer
	dip_config_regs #(
		.DIP_BANKS (DIP_BANKS)
	) dip_config_regs_i (
		.CLK_49M     (CLK_49M),
		.arst_n      (arst_n),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.dip_sw      (dip_sw),
		.is_set3     (is_set3)
	);

	pll_reconfig_seq pll_reconfig_seq_i (
		.CLK_49M         (CLK_49M),
		.arst_n          (arst_n),
		.underclock      (underclock),
		.cfg_waitrequest (cfg_waitrequest),
		.cfg_write       (cfg_write),
		.cfg_address     (cfg_address),
		.cfg_data        (cfg_data)
	);

	color_dac color_dac_i (
		.r_in    (r_in),
		.g_in    (g_in),
		.b_in    (b_in),
		.rgb_out (rgb_out)
	);

endmodule

`default_nettype wire

//--- bench/pll_cfg_assert.sv
//==========================================================================
// PLL management port assertions
// Single-cycle writes, legal addresses and no write under waitrequest
//==========================================================================
`default_nettype none

module pll_cfg_assert
	import arcade_io_pkg::*;
(
	input  wire logic       CLK_49M,
	input  wire logic       arst_n,
	input  wire logic       cfg_waitrequest,
	input  wire logic       cfg_write,
	input  wire logic [5:0] cfg_address
);
	timeunit 1ns;
	timeprecision 1ps;

	// Assertion failures so far
	int fail_count = 0;

	// One-cycle pulse per step
	a_write_pulse: assert property (@(posedge CLK_49M) disable iff (!arst_n)
		cfg_write |=> !cfg_write)
		else begin
			fail_count++;
			$error("cfg_write high on two consecutive cycles");
		end

	// Mode, fraction or start register only
	a_write_addr: assert property (@(posedge CLK_49M) disable iff (!arst_n)
		cfg_write |-> ((cfg_address == PLL_ADDR_MODE) || (cfg_address == PLL_ADDR_FRAC) ||
		(cfg_address == PLL_ADDR_START)))
		else begin
			fail_count++;
			$error("cfg_write to unexpected address %0d", cfg_address);
		end

	a_write_wait: assert property (@(posedge CLK_49M) disable iff (!arst_n)
		cfg_write |-> !cfg_waitrequest)
		else begin
			fail_count++;
			$error("cfg_write issued while cfg_waitrequest is high");
		end

endmodule

bind pll_reconfig_seq pll_cfg_assert pll_cfg_assert_i (
	.CLK_49M         (CLK_49M),
	.arst_n          (arst_n),
	.cfg_waitrequest (cfg_waitrequest),
	.cfg_write       (cfg_write),
	.cfg_address     (cfg_address)
);

`default_nettype wire

//--- bench/tb_checker.sv
//==========================================================================
// Testbench checker
// Reference model of the I/O glue, compares DUT outputs every cycle and
// reports per test
//==========================================================================
`default_nettype none

module tb_checker
	import arcade_io_pkg::*;
#(
	parameter int DIP_BANKS = 2
) (
	input  wire logic                   CLK_49M,
	input  wire logic                   arst_n,
	input  wire logic [KEY_EVENT_W-1:0] ps2_key,
	input  wire logic [15:0]            joystick_0,
	input  wire logic [15:0]            joystick_1,
	input  wire logic                   ioctl_wr,
	input  wire logic [7:0]             ioctl_index,
	input  wire logic [24:0]            ioctl_addr,
	input  wire logic [7:0]             ioctl_dout,
	input  wire logic                   underclock,
	input  wire logic                   cfg_write,
	input  wire logic [5:0]             cfg_address,
	input  wire logic [31:0]            cfg_data,
	input  wire logic [1:0]             coin,
	input  wire logic [1:0]             start_buttons,
	input  wire logic [3:0]             p1_joystick,
	input  wire logic [3:0]             p2_joystick,
	input  wire logic [2:0]             p1_buttons,
	input  wire logic [1:0]             p2_buttons,
	input  wire logic                   btn_service,
	input  wire logic                   pause_n,
	input  wire logic [15:0]            dip_sw,
	input  wire logic                   is_set3,
	input  wire logic [3:0]             r_in,
	input  wire logic [3:0]             g_in,
	input  wire logic [3:0]             b_in,
	input  wire logic [23:0]            rgb_out,
	input  wire logic [2:0]             test_id,
	output int                          error_total,
	output int                          seq_count
);
	timeunit 1ns;
	timeprecision 1ps;

	// Model state
	logic [11:0] m_btn;
	logic        m_tog;
	logic [7:0]  m_dip_lo;
	logic [7:0]  m_dip_hi;
	logic        m_set3;
	logic        m_applied;
	logic [1:0]  write_idx;
	// Bookkeeping
	logic [2:0]  cur_test;
	int          test_checks;
	int          test_errors;
	int          tests_done;
	int          total_checks;

	initial begin
		error_total  = 0;
		seq_count    = 0;
		cur_test     = '0;
		test_checks  = 0;
		test_errors  = 0;
		tests_done   = 0;
		total_checks = 0;
	end

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1: return "keyboard events";
			3'd2: return "joystick merge";
			3'd3: return "DIP and set-3 capture";
			3'd4: return "colour table";
			3'd5: return "PLL reconfiguration";
			default: return "reset state";
		endcase
	endfunction

	// {valid, button position} for a scan code
	function automatic logic [4:0] button_for_code(input logic [7:0] code);
		case (code)
			SC_START1:  return {1'b1, BTN_START1};
			SC_START2:  return {1'b1, BTN_START2};
			SC_COIN1:   return {1'b1, BTN_COIN1};
			SC_COIN2:   return {1'b1, BTN_COIN2};
			SC_SERVICE: return {1'b1, BTN_SERVICE};
			SC_PAUSE:   return {1'b1, BTN_PAUSE};
			SC_UP:      return {1'b1, BTN_UP};
			SC_DOWN:    return {1'b1, BTN_DOWN};
			SC_LEFT:    return {1'b1, BTN_LEFT};
			SC_RIGHT:   return {1'b1, BTN_RIGHT};
			SC_SHOT:    return {1'b1, BTN_SHOT};
			SC_MISSILE: return {1'b1, BTN_MISSILE};
			default:    return 5'd0;
		endcase
	endfunction

	// Controls packed as coin, start, p1 dirs, p2 dirs, p1 btns, p2 btns, svc, pause
	function automatic logic [18:0] expected_controls(
		input logic [11:0] b,
		input logic [15:0] j0,
		input logic [15:0] j1
	);
		logic [15:0] ja;
		logic [3:0]  d1;
		logic [3:0]  d2;
		logic [1:0]  f1;
		logic [1:0]  f2;
		logic [1:0]  c;
		logic [1:0]  s;
		ja = j0 | j1;
		// Right, left, down, up from joystick bits 0..3
		d1 = {b[BTN_RIGHT] | j0[0], b[BTN_LEFT] | j0[1], b[BTN_DOWN] | j0[2], b[BTN_UP] | j0[3]};
		d2 = {b[BTN_RIGHT] | j1[0], b[BTN_LEFT] | j1[1], b[BTN_DOWN] | j1[2], b[BTN_UP] | j1[3]};
		f1 = {b[BTN_MISSILE] | j0[5], b[BTN_SHOT] | j0[4]};
		f2 = {b[BTN_MISSILE] | j1[5], b[BTN_SHOT] | j1[4]};
		// Coin2 stays keyboard only
		c  = {b[BTN_COIN2], b[BTN_COIN1] | ja[7]};
		s  = {b[BTN_START2] | ja[8], b[BTN_START1] | ja[6]};
		return {~c, ~s, ~d1, ~d2, 1'b1, ~f1, ~f2, ~b[BTN_SERVICE], ~(b[BTN_PAUSE] | ja[9])};
	endfunction

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] want);
		test_checks++;
		if (got !== want) begin
			test_errors++;
			error_total++;
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic check_outputs();
		logic [18:0] ctrl_got;
		logic [15:0] dip_want;
		logic [23:0] rgb_want;
		ctrl_got = {coin, start_buttons, p1_joystick, p2_joystick, p1_buttons, p2_buttons,
			btn_service, pause_n};
		dip_want = ~{m_dip_hi, m_dip_lo};
		rgb_want = {COLOR_LEVELS[r_in], COLOR_LEVELS[g_in], COLOR_LEVELS[b_in]};
		compare_value("controls", 32'(ctrl_got),
			32'(expected_controls(m_btn, joystick_0, joystick_1)));
		compare_value("dip_sw", 32'(dip_sw), 32'(dip_want));
		compare_value("is_set3", 32'(is_set3), 32'(m_set3));
		compare_value("rgb_out", 32'(rgb_out), 32'(rgb_want));
	endtask

	// Three writes per settled change, mode then fraction then start
	task automatic check_pll_write();
		logic [31:0] frac;
		if (cfg_write) begin
			case (write_idx)
				2'd0: begin
					if (underclock == m_applied) begin
						test_errors++;
						error_total++;
						$display("PLL write at %0d ns with no underclock change pending", $time);
					end
					m_applied = underclock;
					compare_value("mode address", 32'(cfg_address), 32'(PLL_ADDR_MODE));
					compare_value("mode data", cfg_data, 32'd0);
					write_idx = 2'd1;
				end
				2'd1: begin
					frac = m_applied ? PLL_FRAC_UNDERCLOCK : PLL_FRAC_NATIVE;
					compare_value("fraction address", 32'(cfg_address), 32'(PLL_ADDR_FRAC));
					compare_value("fraction data", cfg_data, frac);
					write_idx = 2'd2;
				end
				default: begin
					compare_value("start address", 32'(cfg_address), 32'(PLL_ADDR_START));
					compare_value("start data", cfg_data, 32'd0);
					write_idx = 2'd0;
					seq_count++;
				end
			endcase
		end
	endtask

	task automatic update_model();
		logic [4:0] sel;
		// Toggle bit flip marks a new key event
		if (ps2_key[10] != m_tog) begin
			sel = button_for_code(ps2_key[7:0]);
			if (sel[4]) begin
				m_btn[sel[3:0]] = ps2_key[9];
			end
		end
		m_tog = ps2_key[10];
		if (ioctl_wr && (ioctl_index == DL_INDEX_DIP) && (ioctl_addr < 25'(DIP_BANKS))) begin
			if (ioctl_addr[0]) begin
				m_dip_hi = ioctl_dout;
			end else begin
				m_dip_lo = ioctl_dout;
			end
		end
		if (ioctl_wr && (ioctl_index == DL_INDEX_ROM) && (ioctl_addr == 25'd0)) begin
			m_set3 = ioctl_dout[0];
		end
	endtask

	//======================================================================
	// Per-cycle compare, then model update for this edge
	//======================================================================
	always @(posedge CLK_49M) begin
		if (test_id != cur_test) begin
			if (cur_test != 3'd0) begin
				$display("Test %0d %s: %0d checks, %0d errors", cur_test, test_name(cur_test),
					test_checks, test_errors);
				tests_done++;
				total_checks += test_checks;
			end
			if ((test_id == 3'd0) && (tests_done > 0)) begin
				$display("Totals: %0d tests, %0d checks, %0d errors", tests_done, total_checks,
					error_total);
			end
			test_checks = 0;
			test_errors = 0;
			cur_test    = test_id;
		end
		if (!arst_n) begin
			m_btn     = '0;
			m_tog     = 1'b0;
			m_dip_lo  = '0;
			m_dip_hi  = '0;
			m_set3    = 1'b0;
			m_applied = 1'b0;
			write_idx = 2'd0;
		end else begin
			check_outputs();
			check_pll_write();
			update_model();
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_top.sv
//==========================================================================
// Arcade I/O testbench top
// Clock, reset, seeded random stimulus per test and the run watchdog
//==========================================================================
`default_nettype none

module tb_top
	import arcade_io_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DIP_BANKS = 2;

	// Test lengths in clock cycles
	localparam int RESET_CYCLES  = 5;
	localparam int IDLE_CYCLES   = 20;
	localparam int KEY_EVENTS    = 200;
	localparam int JOY_CYCLES    = 200;
	localparam int DL_CYCLES     = 200;
	localparam int COLOUR_CYCLES = 100;
	localparam int PLL_FLIPS     = 12;
	// Worst case per flip: sync, eight steps under back-pressure, idle gap
	localparam int PLL_BUDGET    = 64;
	localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + KEY_EVENTS + JOY_CYCLES +
		DL_CYCLES + COLOUR_CYCLES + PLL_FLIPS * PLL_BUDGET + 8;
	localparam int WATCHDOG_NS   = TOTAL_CYCLES * 100 + 2000;

	// Test numbers, shared with the checker labels
	localparam logic [2:0] TEST_KEYS   = 3'd1;
	localparam logic [2:0] TEST_JOYS   = 3'd2;
	localparam logic [2:0] TEST_DIP    = 3'd3;
	localparam logic [2:0] TEST_COLOUR = 3'd4;
	localparam logic [2:0] TEST_PLL    = 3'd5;
	localparam logic [2:0] TEST_RESET  = 3'd6;

	localparam logic [7:0] LISTED_CODES [12] = '{SC_START1, SC_START2, SC_COIN1, SC_COIN2,
		SC_SERVICE, SC_PAUSE, SC_UP, SC_DOWN, SC_LEFT, SC_RIGHT, SC_SHOT, SC_MISSILE};

	logic                   CLK_49M;
	logic                   arst_n;
	logic [KEY_EVENT_W-1:0] ps2_key;
	logic [15:0]            joystick_0;
	logic [15:0]            joystick_1;
	logic                   ioctl_wr;
	logic [7:0]             ioctl_index;
	logic [24:0]            ioctl_addr;
	logic [7:0]             ioctl_dout;
	logic                   underclock;
	logic                   cfg_waitrequest;
	logic                   cfg_write;
	logic [5:0]             cfg_address;
	logic [31:0]            cfg_data;
	logic [1:0]             coin;
	logic [1:0]             start_buttons;
	logic [3:0]             p1_joystick;
	logic [3:0]             p2_joystick;
	logic [2:0]             p1_buttons;
	logic [1:0]             p2_buttons;
	logic                   btn_service;
	logic                   pause_n;
	logic [15:0]            dip_sw;
	logic                   is_set3;
	logic [3:0]             r_in;
	logic [3:0]             g_in;
	logic [3:0]             b_in;
	logic [23:0]            rgb_out;
	// Checker handshake
	logic [2:0]             test_id;
	int                     error_total;
	int                     seq_count;

	tp84_io_top #(
		.DIP_BANKS (DIP_BANKS)
	) tp84_io_top_i (.*);

	tb_checker #(
		.DIP_BANKS (DIP_BANKS)
	) tb_checker_i (.*);

	initial begin
		CLK_49M = 1'b0;
		forever begin
			#50;
			CLK_49M = ~CLK_49M;
		end
	end

	// New PS/2 word, toggle kept in about one case in four
	function automatic logic [KEY_EVENT_W-1:0] next_key_event(
		input logic [KEY_EVENT_W-1:0] prev,
		input logic                   listed_only
	);
		logic [KEY_EVENT_W-1:0] ev;
		logic [3:0]             pick;
		ev = KEY_EVENT_W'($urandom);
		if (listed_only || ($urandom_range(1) == 0)) begin
			pick    = 4'($urandom_range(11));
			ev[7:0] = LISTED_CODES[pick];
		end
		ev[10] = ($urandom_range(3) == 0) ? prev[10] : ~prev[10];
		return ev;
	endfunction

	task automatic send_key_events(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge CLK_49M);
			ps2_key = next_key_event(ps2_key, 1'b0);
		end
	endtask

	task automatic mix_joysticks(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge CLK_49M);
			joystick_0 = 16'($urandom);
			joystick_1 = 16'($urandom);
			if ($urandom_range(1) == 0) begin
				ps2_key = next_key_event(ps2_key, 1'b1);
			end
		end
		@(negedge CLK_49M);
		joystick_0 = '0;
		joystick_1 = '0;
	endtask

	task automatic write_downloads(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge CLK_49M);
			ioctl_wr = 1'($urandom);
			case ($urandom_range(2))
				0: ioctl_index = DL_INDEX_DIP;
				1: ioctl_index = DL_INDEX_ROM;
				default: ioctl_index = 8'($urandom);
			endcase
			// Mostly low addresses so the DIP and ROM decodes hit often
			if ($urandom_range(3) != 0) begin
				ioctl_addr = 25'($urandom_range(3));
			end else begin
				ioctl_addr = 25'($urandom);
			end
			ioctl_dout = 8'($urandom);
		end
		@(negedge CLK_49M);
		ioctl_wr = 1'b0;
	endtask

	task automatic sweep_colours(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge CLK_49M);
			r_in = 4'($urandom);
			g_in = 4'($urandom);
			b_in = 4'($urandom);
		end
	endtask

	// Each flip waits for the checker to see the start write
	task automatic toggle_underclock(input int flips);
		for (int i = 0; i < flips; i++) begin
			@(negedge CLK_49M);
			underclock = ~underclock;
			while (seq_count < i + 1) begin
				@(negedge CLK_49M);
				cfg_waitrequest = ($urandom_range(3) == 0);
			end
			repeat (4) begin
				@(negedge CLK_49M);
				cfg_waitrequest = ($urandom_range(3) == 0);
			end
		end
		@(negedge CLK_49M);
		cfg_waitrequest = 1'b0;
	endtask

	//======================================================================
	// Test sequence
	//======================================================================
	initial begin
		arst_n          = 1'b0;
		ps2_key         = '0;
		joystick_0      = '0;
		joystick_1      = '0;
		ioctl_wr        = 1'b0;
		ioctl_index     = '0;
		ioctl_addr      = '0;
		ioctl_dout      = '0;
		underclock      = 1'b0;
		cfg_waitrequest = 1'b0;
		r_in            = '0;
		g_in            = '0;
		b_in            = '0;
		test_id         = '0;
		void'($urandom(32'h2b68fa86));
		repeat (RESET_CYCLES) @(negedge CLK_49M);
		arst_n  = 1'b1;
		// Idle inputs straight out of reset
		test_id = TEST_RESET;
		repeat (IDLE_CYCLES) @(negedge CLK_49M);
		test_id = TEST_KEYS;
		send_key_events(KEY_EVENTS);
		test_id = TEST_JOYS;
		mix_joysticks(JOY_CYCLES);
		test_id = TEST_DIP;
		write_downloads(DL_CYCLES);
		test_id = TEST_COLOUR;
		sweep_colours(COLOUR_CYCLES);
		test_id = TEST_PLL;
		toggle_underclock(PLL_FLIPS);
		test_id = '0;
		repeat (2) @(negedge CLK_49M);
		if ((error_total == 0) &&
			(tp84_io_top_i.pll_reconfig_seq_i.pll_cfg_assert_i.fail_count == 0)) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, a test did not complete", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
rtl/arcade_io_pkg.sv
rtl/ps2_button_decoder.sv
rtl/control_mapper.sv
rtl/dip_config_regs.sv
rtl/pll_reconfig_seq.sv
rtl/color_dac.sv
rtl/tp84_io_top.sv
bench/pll_cfg_assert.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_top -f tb.f || exit 1
./obj_dir/Vtb_top > sim.log 2>&1
status=$?
cat sim.log
# A crash or failed assertion counts as failure too
[ "$status" -eq 0 ] && ! grep -q "Simulation failed" sim.log || exit 1
exit 0
